// File: Bender.yml
package:
  name: frameBuf

sources:
  - files:
      - hw/fbPkg.sv
      - hw/frameCtrl.sv
      - hw/vgaTiming.sv
      - hw/blockAddrGen.sv
      - hw/pingPongRam.sv
      - hw/frameBufTop.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tbFrameBuf.sv

// File: hw/blockAddrGen.sv
// First scan-out stage mapping pixel position to a 10x10 block index with blanked positions at 0
`timescale 1ns/10ps

module blockAddrGen import fbPkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  scanPos_t  pos,
    output blockIdx_t index,
    output vidCtl_t   ctl
);

    blockIdx_t colIdx;
    blockIdx_t rowIdx;
    blockIdx_t idxNext;

    // Coarsen to block coordinates
    assign colIdx = blockIdx_t'(pos.x / BLOCK_SIZE);
    assign rowIdx = blockIdx_t'(pos.y / BLOCK_SIZE);

    // Row major grid
    assign idxNext = rowIdx * blockIdx_t'(GRID_W) + colIdx;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            index <= '0;
            ctl   <= VID_IDLE;
        end else begin
            index <= pos.ctl.active ? idxNext : '0; // Blanked positions stay inside the bank
            ctl   <= pos.ctl; // Same delay as the index
        end
    end

endmodule

// File: hw/fbPkg.sv
// Shared constants and types for a 640x480 block framebuffer on one clock with no byte strobes
package fbPkg;

    // Horizontal timing in pixel clocks
    localparam int H_ACTIVE = 640;
    localparam int H_FRONT  = 16;
    localparam int H_SYNC   = 96;
    localparam int H_BACK   = 48;
    localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK; // 800

    // Vertical timing in lines
    localparam int V_ACTIVE = 480;
    localparam int V_FRONT  = 10;
    localparam int V_SYNC   = 2;
    localparam int V_BACK   = 33;
    localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK; // 525

    // Sync pulse windows
    localparam int H_SYNC_START = H_ACTIVE + H_FRONT;
    localparam int H_SYNC_END   = H_SYNC_START + H_SYNC;
    localparam int V_SYNC_START = V_ACTIVE + V_FRONT;
    localparam int V_SYNC_END   = V_SYNC_START + V_SYNC;

    // Block grid
    localparam int BLOCK_SIZE = 10;                   // Pixels per block edge
    localparam int GRID_W     = H_ACTIVE / BLOCK_SIZE; // 64 blocks across
    localparam int GRID_H     = V_ACTIVE / BLOCK_SIZE; // 48 blocks down
    localparam int GRID_SIZE  = 4800;                 // Bank depth above the visible 64x48 grid

    typedef logic [7:0]  pixel_t;    // One colour value per block
    typedef logic [9:0]  hCount_t;
    typedef logic [9:0]  vCount_t;
    typedef logic [12:0] blockIdx_t;
    typedef logic [15:0] axiAddr_t;  // Byte address
    typedef logic [31:0] axiData_t;
    typedef logic [1:0]  axiResp_t;

    // Register map
    localparam axiAddr_t CTRL_ADDR   = 16'h0000; // Bit 0 requests a swap
    localparam axiAddr_t STATUS_ADDR = 16'h0004; // Bit 0 front bank and bit 1 pending
    localparam axiAddr_t PIX_BASE    = 16'h8000; // One word per block
    localparam axiResp_t RESP_OKAY   = 2'b00;
    localparam axiResp_t RESP_SLVERR = 2'b10;

    // Master to slave
    typedef struct packed {
        axiAddr_t awaddr;
        logic     awvalid;
        axiData_t wdata;
        logic     wvalid;
        logic     bready;
        axiAddr_t araddr;
        logic     arvalid;
        logic     rready;
    } axiReq_t;

    // Slave to master
    typedef struct packed {
        logic     awready;
        logic     wready;
        axiResp_t bresp;
        logic     bvalid;
        logic     arready;
        axiData_t rdata;
        axiResp_t rresp;
        logic     rvalid;
    } axiRsp_t;

    typedef struct packed {
        logic      valid; // Single cycle strobe
        blockIdx_t index;
        pixel_t    data;
    } pixWrite_t;

    typedef struct packed {
        logic hsync;  // Active low
        logic vsync;  // Active low
        logic active;
    } vidCtl_t;

    typedef struct packed {
        hCount_t x;
        vCount_t y;
        vidCtl_t ctl;
    } scanPos_t;

    // Blank video with both syncs idle
    localparam vidCtl_t VID_IDLE = '{hsync: 1'b1, vsync: 1'b1, active: 1'b0};

    typedef enum logic [1:0] {
        IDLE,
        WRITE_RESP,
        READ_RESP
    } ctrlState_t;

endpackage

// File: hw/frameBufTop.sv
// Framebuffer top on a single clock with AXI4-Lite writes in and VGA block video out two clocks late
`timescale 1ns/10ps

module frameBufTop import fbPkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  axiReq_t axiIn,
    output axiRsp_t axiOut,
    output pixel_t  rgb,
    output vidCtl_t video
);

    logic      frameStart; // Top left of frame
    logic      frontBank;
    pixWrite_t pixWr;
    scanPos_t  pos;
    blockIdx_t rdIndex;
    vidCtl_t   rdCtl;

    // Bus side and bank select
    frameCtrl u_frameCtrl (
        .clk        (clk),
        .rst        (rst),
        .axiIn      (axiIn),
        .axiOut     (axiOut),
        .frameStart (frameStart),
        .pixWr      (pixWr),
        .frontBank  (frontBank)
    );

    // Scan counters
    vgaTiming u_vgaTiming (
        .clk        (clk),
        .rst        (rst),
        .pos        (pos),
        .frameStart (frameStart)
    );

    // Stage 1
    blockAddrGen u_blockAddrGen (
        .clk   (clk),
        .rst   (rst),
        .pos   (pos),
        .index (rdIndex),
        .ctl   (rdCtl)
    );

    // Stage 2
    pingPongRam u_pingPongRam (
        .clk       (clk),
        .rst       (rst),
        .pixWr     (pixWr),
        .frontBank (frontBank),
        .rdIndex   (rdIndex),
        .rdCtl     (rdCtl),
        .rgb       (rgb),
        .video     (video)
    );

endmodule

// File: hw/frameCtrl.sv
// AXI4-Lite slave with one outstanding transfer where writes win over reads and swaps land at frame start
`timescale 1ns/10ps

module frameCtrl import fbPkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  axiReq_t   axiIn,
    output axiRsp_t   axiOut,
    input  logic      frameStart,
    output pixWrite_t pixWr,
    output logic      frontBank
);

    ctrlState_t state;
    logic       wrFire;   // Address and data taken together
    logic       rdFire;
    axiAddr_t   wrOff;
    blockIdx_t  wrIdx;
    logic       wrCtrl;
    logic       wrPix;
    logic       swapReq;
    logic       pending;  // Swap waiting for frame start
    axiResp_t   bresp;
    axiResp_t   rresp;
    axiData_t   rdata;

    // Write needs both channels in the same cycle
    assign wrFire = (state == IDLE) && axiIn.awvalid && axiIn.wvalid;

    // Any write activity blocks a read
    assign rdFire = (state == IDLE) && axiIn.arvalid && !axiIn.awvalid && !axiIn.wvalid;

    // Word offset into pixel region
    assign wrOff  = axiIn.awaddr - PIX_BASE;
    assign wrIdx  = blockIdx_t'(wrOff >> 2);

    assign wrCtrl = (axiIn.awaddr == CTRL_ADDR);
    assign wrPix  = (axiIn.awaddr >= PIX_BASE) && (wrIdx < GRID_SIZE); // In-range blocks only

    assign swapReq = wrFire && wrCtrl && axiIn.wdata[0];

    // Pixel goes to the RAM on the handshake edge
    always_comb begin
        pixWr.valid = wrFire && wrPix;
        pixWr.index = wrIdx;
        pixWr.data  = axiIn.wdata[$bits(pixel_t)-1:0];
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (wrFire) begin
                        state <= WRITE_RESP;
                    end else if (rdFire) begin
                        state <= READ_RESP;
                    end
                end
                WRITE_RESP: begin
                    if (axiIn.bready) begin
                        state <= IDLE; // Response taken
                    end
                end
                READ_RESP: begin
                    if (axiIn.rready) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Response payload held until the master accepts
    always_ff @(posedge clk) begin
        if (wrFire) begin
            bresp <= (wrCtrl || wrPix) ? RESP_OKAY : RESP_SLVERR;
        end
        if (rdFire) begin
            if (axiIn.araddr == STATUS_ADDR) begin
                rdata <= axiData_t'({pending, frontBank});
                rresp <= RESP_OKAY;
            end else begin
                rdata <= '0;          // Pixel reads and holes
                rresp <= RESP_SLVERR;
            end
        end
    end

    // Bank swap
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pending   <= 1'b0;
            frontBank <= 1'b0;
        end else if (frameStart && pending) begin
            frontBank <= !frontBank; // Flip between frames only
            pending   <= 1'b0;
        end else if (swapReq) begin
            pending   <= 1'b1;       // Repeat request just stays set
        end
    end

    always_comb begin
        axiOut.awready = wrFire;
        axiOut.wready  = wrFire;
        axiOut.bresp   = bresp;
        axiOut.bvalid  = (state == WRITE_RESP);
        axiOut.arready = rdFire;
        axiOut.rdata   = rdata;
        axiOut.rresp   = rresp;
        axiOut.rvalid  = (state == READ_RESP);
    end

endmodule

// File: hw/pingPongRam.sv
// Two block banks with host writes to the back bank and a one-cycle registered read of the front bank
`timescale 1ns/10ps

module pingPongRam import fbPkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  pixWrite_t pixWr,
    input  logic      frontBank,
    input  blockIdx_t rdIndex,
    input  vidCtl_t   rdCtl,
    output pixel_t    rgb,
    output vidCtl_t   video
);

    // Bank 0 and bank 1 side by side
    pixel_t mem [2][GRID_SIZE];
    pixel_t rdData;
    logic   backBank;

    assign backBank = !frontBank;

    // Write port into back bank
    always_ff @(posedge clk) begin
        if (pixWr.valid) begin
            mem[backBank][pixWr.index] <= pixWr.data;
        end
    end

    // Read port on front bank
    always_ff @(posedge clk) begin
        rdData <= mem[frontBank][rdIndex];
    end

    // Control follows the read data
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            video <= VID_IDLE;
        end else begin
            video <= rdCtl;
        end
    end

    // Black outside the visible area
    assign rgb = video.active ? rdData : '0;

endmodule

// File: hw/vgaTiming.sv
// Free-running 800x525 scan counters with active-low syncs and no blanking offset on outputs
`timescale 1ns/10ps

module vgaTiming import fbPkg::*; (
    input  logic     clk,
    input  logic     rst,
    output scanPos_t pos,
    output logic     frameStart
);

    hCount_t hCount;
    vCount_t vCount;
    logic    hEnd;
    logic    vEnd;
    logic    hSyncOn;
    logic    vSyncOn;

    assign hEnd = (hCount == hCount_t'(H_TOTAL - 1)); // Last clock of line
    assign vEnd = (vCount == vCount_t'(V_TOTAL - 1)); // Last line of frame

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hCount <= '0;
            vCount <= '0;
        end else if (hEnd) begin
            hCount <= '0;
            if (vEnd) begin
                vCount <= '0; // Wrap to next frame
            end else begin
                vCount <= vCount + 1'b1;
            end
        end else begin
            hCount <= hCount + 1'b1;
        end
    end

    // Sync windows from the front porch end
    assign hSyncOn = (hCount >= H_SYNC_START) && (hCount < H_SYNC_END);
    assign vSyncOn = (vCount >= V_SYNC_START) && (vCount < V_SYNC_END);

    always_comb begin
        pos.x          = hCount;
        pos.y          = vCount;
        pos.ctl.hsync  = !hSyncOn;
        pos.ctl.vsync  = !vSyncOn;
        pos.ctl.active = (hCount < H_ACTIVE) && (vCount < V_ACTIVE);
    end

    // One clock at the top left corner
    assign frameStart = (hCount == '0) && (vCount == '0);

endmodule

// File: list.f
+incdir+testbench
hw/fbPkg.sv
hw/frameCtrl.sv
hw/vgaTiming.sv
hw/blockAddrGen.sv
hw/pingPongRam.sv
hw/frameBufTop.sv
testbench/tbFrameBuf.sv

// File: testbench/tbFrameBufTasks.svh
// Bus helpers and pixel model for tbFrameBuf; drives on the falling edge and assumes one transfer at a time
`ifndef TB_FRAME_BUF_TASKS_SVH
`define TB_FRAME_BUF_TASKS_SVH

// Count and report every mismatch
task automatic checkVal(input string name, input logic [31:0] actual, input logic [31:0] expected);
    if (actual !== expected) begin
        errCount++;
        $display("** Error at %0t: %s got %0h expected %0h", $time, name, actual, expected);
    end
endtask

// Single write, bready held low for stall cycles once bvalid shows
task automatic axiWrite(input axiAddr_t addr, input axiData_t data, input int stall,
                        output axiResp_t resp);
    @(negedge clk);
    axiIn.awaddr  = addr;
    axiIn.awvalid = 1'b1;
    axiIn.wdata   = data;
    axiIn.wvalid  = 1'b1;
    axiIn.bready  = 1'b0;
    #1;                                        // Let ready settle
    while (!(axiOut.awready && axiOut.wready)) begin
        @(negedge clk);
        #1;
    end
    @(negedge clk);                            // Handshake edge passed
    axiIn.awvalid = 1'b0;
    axiIn.wvalid  = 1'b0;
    while (!axiOut.bvalid) @(negedge clk);
    repeat (stall) begin
        @(negedge clk);
        checkVal("bvalid", axiOut.bvalid, 1); // Must hold under back-pressure
    end
    resp = axiOut.bresp;
    axiIn.bready = 1'b1;
    @(negedge clk);
    axiIn.bready = 1'b0;
endtask

// Single read, same shape as the write
task automatic axiRead(input axiAddr_t addr, input int stall, output axiData_t data,
                       output axiResp_t resp);
    @(negedge clk);
    axiIn.araddr  = addr;
    axiIn.arvalid = 1'b1;
    axiIn.rready  = 1'b0;
    #1;
    while (!axiOut.arready) begin
        @(negedge clk);
        #1;
    end
    @(negedge clk);
    axiIn.arvalid = 1'b0;
    while (!axiOut.rvalid) @(negedge clk);
    repeat (stall) begin
        @(negedge clk);
        checkVal("rvalid", axiOut.rvalid, 1);
    end
    data = axiOut.rdata;
    resp = axiOut.rresp;
    axiIn.rready = 1'b1;
    @(negedge clk);
    axiIn.rready = 1'b0;
endtask

// Expected colour at a screen position, black when blanked
function automatic pixel_t refPixel(input int bank, input int x, input int y);
    if (x < H_ACTIVE && y < V_ACTIVE) begin
        return modelBank[bank][(y / BLOCK_SIZE) * GRID_W + x / BLOCK_SIZE];
    end
    return '0;
endfunction

`endif

// File: testbench/tbFrameBuf.sv
// Framebuffer testbench; a full capture takes up to two frames, so the run lasts several million cycles
`timescale 1ns/10ps

module tbFrameBuf import fbPkg::*; ();

    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    // 14 frames of waiting and capture plus 4 bank fills at up to 8 cycles per write
    localparam int TIMEOUT_CYCLES = 14 * FRAME_CYCLES + 4 * GRID_SIZE * 8;
    localparam int TOP_LINES = 20;            // Partial capture depth
    localparam int TOP_CYCLES = (V_TOTAL - V_SYNC_END + TOP_LINES) * H_TOTAL;

    logic    clk = 1'b0;
    logic    rst;
    axiReq_t axiIn;
    axiRsp_t axiOut;
    pixel_t  rgb;
    vidCtl_t video;

    pixel_t   modelBank [2][GRID_SIZE];       // Mirror of the RAM
    int       modelFront;
    integer   seed = 32'h82e1de70;
    int       errCount = 0;
    int       errBase;
    int       passCount = 0;
    int       failCount = 0;
    int       cycleCount = 0;
    axiData_t rdData;
    axiResp_t resp;

    // Capture request and statistics
    logic capStart = 1'b0;
    logic capDone;
    int   capBank;
    int   capCycles;
    int   capX, capY, capN;
    int   statActive, statHsLow, statVsLow, statLines, runMin, runMax;
    int   lastFall, hsPerMin, hsPerMax;
    logic prevHs;

    frameBufTop u_frameBufTop (
        .clk    (clk),
        .rst    (rst),
        .axiIn  (axiIn),
        .axiOut (axiOut),
        .rgb    (rgb),
        .video  (video)
    );

    `include "tbFrameBufTasks.svh"

    always #5 clk = ~clk;                     // 10 ns period

    // Watchdog
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("Run stopped: no finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test FAILED");
            $finish;
        end
    end

    // Frame compare, window opens at the vsync rising edge
    always begin
        wait (capStart);
        @(negedge clk);
        while (video.vsync !== 1'b0) @(negedge clk);
        while (video.vsync !== 1'b1) @(negedge clk);
        capX = 0;
        capY = 0;
        statActive = 0;
        statHsLow = 0;
        statVsLow = 0;
        runMin = 1 << 30;
        runMax = 0;
        lastFall = -1;
        hsPerMin = 1 << 30;
        hsPerMax = 0;
        prevHs = video.hsync;
        for (capN = 0; capN < capCycles; capN++) begin
            if (video.active) begin
                checkVal("rgb", rgb, refPixel(capBank, capX, capY));
                capX++;
                statActive++;
            end else begin
                if (capX > 0) begin                       // Line just ended
                    runMin = (capX < runMin) ? capX : runMin;
                    runMax = (capX > runMax) ? capX : runMax;
                    capY++;
                    capX = 0;
                end
                checkVal("rgb blank", rgb, 0);
            end
            if (!video.hsync) statHsLow++;
            if (!video.vsync) statVsLow++;
            if (!video.hsync && prevHs) begin             // hsync falling
                if (lastFall >= 0) begin
                    hsPerMin = (capN - lastFall < hsPerMin) ? capN - lastFall : hsPerMin;
                    hsPerMax = (capN - lastFall > hsPerMax) ? capN - lastFall : hsPerMax;
                end
                lastFall = capN;
            end
            prevHs = video.hsync;
            @(negedge clk);
        end
        statLines = capY;
        capDone = 1'b1;
        wait (!capStart);
    end

    task automatic capture(input int bank, input int cycles);
        capBank = bank;
        capCycles = cycles;
        capDone = 1'b0;
        capStart = 1'b1;
        wait (capDone);
        capStart = 1'b0;
    endtask

    // Random fill of the current back bank
    task automatic fillBack();
        axiData_t d;
        for (int i = 0; i < GRID_SIZE; i++) begin
            d = $random(seed);
            axiWrite(axiAddr_t'(PIX_BASE + i * 4), d, 0, resp);
            checkVal("fill bresp", resp, RESP_OKAY);
            modelBank[1 - modelFront][i] = d[7:0];
        end
    endtask

    // Request swap and poll until pending clears
    task automatic swapAndWait();
        axiWrite(CTRL_ADDR, 32'h1, 0, resp);
        checkVal("ctrl bresp", resp, RESP_OKAY);
        do begin
            axiRead(STATUS_ADDR, 0, rdData, resp);
            checkVal("status rresp", resp, RESP_OKAY);
        end while (rdData[1] === 1'b1);
        modelFront = 1 - modelFront;
        checkVal("status front", rdData[0], modelFront);
    endtask

    task automatic endTest(input int num, input string name);
        if (errCount == errBase) begin
            passCount++;
            $display("Test %0d %s: pass", num, name);
        end else begin
            failCount++;
            $display("Test %0d %s: fail with %0d errors", num, name, errCount - errBase);
        end
        errBase = errCount;
    endtask

    initial begin
        axiIn = '0;
        rst = 1'b1;
        modelFront = 0;
        errBase = 0;

        // 1 Reset state
        repeat (4) begin
            @(negedge clk);
            checkVal("video", video, VID_IDLE);
            checkVal("rgb", rgb, 0);
        end
        rst = 1'b0;
        @(negedge clk);
        checkVal("video", video, VID_IDLE); // Pipe still empty
        checkVal("rgb", rgb, 0);
        axiRead(STATUS_ADDR, 0, rdData, resp);
        checkVal("status", rdData, 0);
        checkVal("status rresp", resp, RESP_OKAY);
        endTest(1, "reset state");

        // 2 Fill bank 1 and show it
        fillBack();
        swapAndWait();
        capture(modelFront, FRAME_CYCLES);
        endTest(2, "bank 1 frame");

        // 3 Timing from the same capture
        checkVal("active cycles", statActive, H_ACTIVE * V_ACTIVE);
        checkVal("active lines", statLines, V_ACTIVE);
        checkVal("line run min", runMin, H_ACTIVE);
        checkVal("line run max", runMax, H_ACTIVE);
        checkVal("hsync low cycles", statHsLow, H_SYNC * V_TOTAL);
        checkVal("vsync low cycles", statVsLow, V_SYNC * H_TOTAL);
        checkVal("line period min", hsPerMin, H_TOTAL);
        checkVal("line period max", hsPerMax, H_TOTAL);
        endTest(3, "sync timing");

        // 4 Back bank writes stay hidden until swapped
        fillBack();
        capture(modelFront, FRAME_CYCLES);
        swapAndWait();
        capture(modelFront, FRAME_CYCLES);
        endTest(4, "ping-pong");

        // 5 Error responses
        axiWrite(axiAddr_t'(PIX_BASE + GRID_SIZE * 4), 32'h55, 0, resp);
        checkVal("index 4800 bresp", resp, RESP_SLVERR);
        axiRead(PIX_BASE, 0, rdData, resp);
        checkVal("pixel read rresp", resp, RESP_SLVERR);
        axiWrite(STATUS_ADDR, 32'h3, 0, resp);
        checkVal("status write bresp", resp, RESP_SLVERR);
        axiWrite(16'h0100, 32'h1, 0, resp);
        checkVal("unmapped bresp", resp, RESP_SLVERR);
        axiRead(16'h0100, 0, rdData, resp);
        checkVal("unmapped rresp", resp, RESP_SLVERR);
        swapAndWait();                        // Bank that took the rejected writes
        capture(modelFront, TOP_CYCLES);
        endTest(5, "error responses");

        // 6 Stalled write response
        axiWrite(axiAddr_t'(PIX_BASE + 3 * 4), 32'hA5, 20, resp);
        checkVal("stalled bresp", resp, RESP_OKAY);
        modelBank[1 - modelFront][3] = 8'hA5;
        swapAndWait();
        capture(modelFront, TOP_CYCLES);
        endTest(6, "back-pressure");

        $display("Summary: %0d tests passed, %0d failed, %0d check errors",
                 passCount, failCount, errCount);
        if (failCount == 0 && errCount == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule
